//--- tb.f
cu_seq_pkg.sv
cu_dp_pkg.sv
ctrl_word_if.sv
ctrl_sequencer.sv
microcode_rom.sv
ctrl_line_decoder.sv
control_unit.sv
control_unit_asserts.sv
tb_clock_gen.sv
tb_control_unit.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_control_unit -f tb.f -o sim_tb

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation clean"

//--- tb_control_unit.sv
`default_nettype none

module tb_control_unit;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int MOVE_RUNS = 12;
	// fetch plus the longest execute sequence, with slack
	localparam int MAX_INSTR_CYCLES = 12;
	// nop, loads, store, moves, jumps, alu ops, other class, end
	localparam int INSTR_COUNT = 4 + MOVE_RUNS + 4 + 3 + 1 + 1;
	localparam int WATCH_CYCLES = 2 * (RESET_CYCLES + 8 + INSTR_COUNT * MAX_INSTR_CYCLES + 16);

	// single cycle opcodes, moves, increments and clears
	localparam logic [5:0] SINGLE_OPS [20] = '{
		cu_seq_pkg::op_mvr2r1, cu_seq_pkg::op_mvacarp, cu_seq_pkg::op_mvacacp,
		cu_seq_pkg::op_mvacbcp, cu_seq_pkg::op_incam, cu_seq_pkg::op_incan,
		cu_seq_pkg::op_incbn, cu_seq_pkg::op_mvamr1, cu_seq_pkg::op_mvanr1,
		cu_seq_pkg::op_mvbnr1, cu_seq_pkg::op_mvarpac, cu_seq_pkg::op_mvacpac,
		cu_seq_pkg::op_mvbcpac, cu_seq_pkg::op_mvaaac, cu_seq_pkg::op_mvabac,
		cu_seq_pkg::op_mvadac, cu_seq_pkg::op_mvacr1, cu_seq_pkg::op_mvacr2,
		cu_seq_pkg::op_rstan, cu_seq_pkg::op_rstr2
	};

	logic clock;
	logic arst_n;
	logic [15:0] z;
	logic [1:0] status;
	logic [15:0] instruction;
	logic [2:0] alu_op;
	logic [15:0] write_en;
	logic [3:0] read_en;
	logic [2:0] clr_en;
	logic [15:0] inc_en;
	logic mem_wr;
	logic end_process;

	logic [31:0] rng_state = 32'hb677;
	logic [31:0] r;
	logic [4:0] idx;
	int tb_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int mark = 0;

	tb_clock_gen #(
		.PERIOD(PERIOD),
		.RESET_CYCLES(RESET_CYCLES)
	) clk_gen (
		.clock(clock),
		.arst_n(arst_n)
	);

	control_unit uut (
		.clock(clock),
		.arst_n(arst_n),
		.z(z),
		.status(status),
		.instruction(instruction),
		.alu_op(alu_op),
		.write_en(write_en),
		.read_en(read_en),
		.clr_en(clr_en),
		.inc_en(inc_en),
		.mem_wr(mem_wr),
		.end_process(end_process)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_random(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	// tb timeouts plus assertion failures
	function automatic int total_errors();
		return tb_errors + uut.u_asserts.fail_count;
	endfunction

	// memory at pc onto the bus, into ir
	function automatic logic at_fetch1();
		return (read_en == 4'd15) && (write_en == 16'h0008);
	endfunction

	task automatic wait_fetch1();
		int n;
		n = 0;
		@(negedge clock);
		while (!at_fetch1() && n < MAX_INSTR_CYCLES) begin
			@(negedge clock);
			n++;
		end
		if (!at_fetch1()) begin
			tb_errors++;
			$display("no return to fetch within %0d cycles at %0t", MAX_INSTR_CYCLES, $time);
		end
	endtask

	// called in fetch1, instruction held until the next fetch1
	task automatic run_instr(input logic [3:0] cls, input logic [5:0] op,
		input logic [15:0] zval);
		logic [31:0] v;
		next_random(v);
		// random filler between class and opcode
		instruction = {cls, v[5:0], op};
		z = zval;
		wait_fetch1();
	endtask

	task automatic begin_test();
		mark = total_errors();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (total_errors() != mark) begin
			tests_failed++;
			$display("%s: failed", name);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic run_end();
		int n;
		instruction = {4'd15, 6'd0, 6'(cu_seq_pkg::op_end)};
		n = 0;
		while (!end_process && n < MAX_INSTR_CYCLES) begin
			@(negedge clock);
			n++;
		end
		if (!end_process) begin
			tb_errors++;
			$display("end_process never rose after the end opcode at %0t", $time);
		end
		// halt should hold
		repeat (8) @(negedge clock);
	endtask

	initial begin
		status = 2'b00;
		instruction = '0;
		z = '0;
		wait (arst_n === 1'b1);
		@(negedge clock);

		begin_test();
		// idle window with no start
		repeat (4) @(negedge clock);
		status = cu_seq_pkg::START_STATUS;
		wait_fetch1();
		status = 2'b00;
		end_test("reset and idle");

		begin_test();
		run_instr(4'd8, cu_seq_pkg::op_nop, 16'h0000);
		run_instr(4'd8, cu_seq_pkg::op_loada, 16'h0000);
		run_instr(4'd15, cu_seq_pkg::op_loadb, 16'h0000);
		run_instr(4'd8, cu_seq_pkg::op_store, 16'h0000);
		end_test("fetch, loads and store");

		begin_test();
		for (int i = 0; i < MOVE_RUNS; i++) begin
			next_random(r);
			idx = 5'(r % 32'd20);
			run_instr(r[7] ? 4'd15 : 4'd8, SINGLE_OPS[idx], r[31:16]);
		end
		end_test("moves, increments and clears");

		begin_test();
		next_random(r);
		run_instr(4'd8, cu_seq_pkg::op_jumpz, 16'h0000);
		run_instr(4'd8, cu_seq_pkg::op_jumpz, r[15:0] | 16'h0001);
		run_instr(4'd15, cu_seq_pkg::op_jumpn, r[31:16] | 16'h0001);
		run_instr(4'd15, cu_seq_pkg::op_jumpn, 16'h0000);
		end_test("conditional jumps");

		begin_test();
		run_instr(4'd8, cu_seq_pkg::op_multi, 16'h0000);
		run_instr(4'd15, cu_seq_pkg::op_add, 16'h0000);
		run_instr(4'd8, cu_seq_pkg::op_sub, 16'h0000);
		// class 0 to 7 never executes
		next_random(r);
		run_instr({1'b0, r[2:0]}, r[9:4], 16'h0000);
		end_test("alu ops and other class");

		begin_test();
		run_end();
		end_test("end");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCH_CYCLES * PERIOD);
		$display("watchdog expired after %0d cycles", WATCH_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ns;

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// release on a falling edge, clear of the state register
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- control_unit_asserts.sv
`default_nettype none

module control_unit_asserts (
	input logic clock,
	input logic arst_n,
	input logic [1:0] status,
	input logic [15:0] instruction,
	input logic [15:0] z,
	input cu_seq_pkg::state_t present,
	input logic [3:0] read_en,
	input logic [15:0] write_en,
	input logic [15:0] inc_en,
	input logic [2:0] clr_en,
	input logic [2:0] alu_op,
	input logic mem_wr,
	input logic end_process
);
	timeunit 1ns;
	timeprecision 1ns;

	int fail_count = 0;

	cu_seq_pkg::state_t prev_state;
	cu_seq_pkg::state_t prev2_state;
	logic [15:0] prev_instr;
	logic [39:0] single_exp;
	logic [2:0] alu_exp;
	logic decoded;
	logic exec_class;
	logic single_hit;
	logic alu_hit;
	logic other_hit;
	logic jump_taken;
	logic jump_skip;

	// hit flag, bus source, write lines, increment lines, clear code
	function automatic logic [39:0] single_lines(input logic [5:0] op);
		case (op)
			// r2 to r1
			6'd20: return {1'b1, 4'd2, 16'h0400, 16'h0000, 3'd0};
			// ac to arp, acp, bcp
			6'd23: return {1'b1, 4'd12, 16'h0080, 16'h0000, 3'd0};
			6'd24: return {1'b1, 4'd12, 16'h0100, 16'h0000, 3'd0};
			6'd25: return {1'b1, 4'd12, 16'h0200, 16'h0000, 3'd0};
			// increments am, an, bn
			6'd26: return {1'b1, 4'd0, 16'h0000, 16'h0010, 3'd0};
			6'd27: return {1'b1, 4'd0, 16'h0000, 16'h0020, 3'd0};
			6'd28: return {1'b1, 4'd0, 16'h0000, 16'h0040, 3'd0};
			// counters to r1
			6'd29: return {1'b1, 4'd5, 16'h0400, 16'h0000, 3'd0};
			6'd30: return {1'b1, 4'd6, 16'h0400, 16'h0000, 3'd0};
			6'd31: return {1'b1, 4'd7, 16'h0400, 16'h0000, 3'd0};
			// pointers and address regs to ac
			6'd32: return {1'b1, 4'd8, 16'h0800, 16'h0000, 3'd0};
			6'd33: return {1'b1, 4'd9, 16'h0800, 16'h0000, 3'd0};
			6'd34: return {1'b1, 4'd10, 16'h0800, 16'h0000, 3'd0};
			6'd35: return {1'b1, 4'd1, 16'h0800, 16'h0000, 3'd0};
			6'd36: return {1'b1, 4'd3, 16'h0800, 16'h0000, 3'd0};
			6'd37: return {1'b1, 4'd13, 16'h0800, 16'h0000, 3'd0};
			// ac to r1, r2
			6'd38: return {1'b1, 4'd12, 16'h0400, 16'h0000, 3'd0};
			6'd39: return {1'b1, 4'd12, 16'h0002, 16'h0000, 3'd0};
			// clears
			6'd45: return {1'b1, 4'd0, 16'h0000, 16'h0000, 3'd1};
			6'd46: return {1'b1, 4'd0, 16'h0000, 16'h0000, 3'd2};
			default: return '0;
		endcase
	endfunction

	function automatic logic [2:0] alu_code(input logic [5:0] op);
		case (op)
			6'd41: return 3'd1;
			6'd42: return 3'd2;
			6'd43: return 3'd3;
			default: return 3'd0;
		endcase
	endfunction

	// instruction is taken at the end of fetch2x
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			prev_state <= cu_seq_pkg::st_idle;
			prev2_state <= cu_seq_pkg::st_idle;
			prev_instr <= '0;
		end else begin
			prev_state <= present;
			prev2_state <= prev_state;
			prev_instr <= instruction;
		end
	end

	assign decoded = (prev_state == cu_seq_pkg::st_fetch2x);
	assign exec_class = (prev_instr[15:12] == 4'd8) || (prev_instr[15:12] == 4'd15);
	assign single_exp = single_lines(prev_instr[5:0]);
	assign alu_exp = alu_code(prev_instr[5:0]);
	assign single_hit = decoded && exec_class && single_exp[39];
	assign alu_hit = decoded && exec_class && (alu_exp != 3'd0);
	assign other_hit = decoded && !exec_class;
	// jumpz taken on zero, jumpn on nonzero
	assign jump_taken = (present == cu_seq_pkg::st_jumpz1 && z == '0) ||
		(present == cu_seq_pkg::st_jumpn1 && z != '0);
	assign jump_skip = (present == cu_seq_pkg::st_jumpz1 && z != '0) ||
		(present == cu_seq_pkg::st_jumpn1 && z == '0);

	a_idle_quiet: assert property (@(posedge clock) disable iff (!arst_n)
		present == cu_seq_pkg::st_idle |->
		{read_en, write_en, inc_en, clr_en, alu_op, mem_wr, end_process} == '0)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t %s got %h expected 0", $time,
			"read_en,write_en,inc_en,clr_en,alu_op,mem_wr,end_process",
			{read_en, write_en, inc_en, clr_en, alu_op, mem_wr, end_process});
	end

	a_start: assert property (@(posedge clock) disable iff (!arst_n)
		present == cu_seq_pkg::st_idle && status == 2'b01 |=> present == cu_seq_pkg::st_fetch1)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t present got %0d expected %0d", $time, present, cu_seq_pkg::st_fetch1);
	end

	a_fetch1: assert property (@(posedge clock) disable iff (!arst_n)
		present == cu_seq_pkg::st_fetch1 |-> read_en == 4'd15 && write_en == 16'h0008)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t read_en/write_en got %h/%h expected f/0008", $time, read_en, write_en);
	end

	// pc increment two cycles after fetch1
	a_fetch2: assert property (@(posedge clock) disable iff (!arst_n)
		prev2_state == cu_seq_pkg::st_fetch1 |-> inc_en == 16'h0004)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t inc_en got %h expected 0004", $time, inc_en);
	end

	a_single: assert property (@(posedge clock) disable iff (!arst_n)
		single_hit |-> {read_en, write_en, inc_en, clr_en} == single_exp[38:0])
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t read_en,write_en,inc_en,clr_en got %h expected %h", $time,
			{read_en, write_en, inc_en, clr_en}, single_exp[38:0]);
	end

	// store writes r2 to memory in its second cycle
	a_store: assert property (@(posedge clock) disable iff (!arst_n)
		decoded && exec_class && prev_instr[5:0] == 6'd7 |=>
		mem_wr && read_en == 4'd2 && write_en == 16'h2000)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t mem_wr/read_en/write_en got %b/%h/%h expected 1/2/2000", $time,
			mem_wr, read_en, write_en);
	end

	// other classes give one empty cycle
	a_other: assert property (@(posedge clock) disable iff (!arst_n)
		other_hit |-> {read_en, write_en, inc_en, clr_en, alu_op, mem_wr} == '0)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t %s got %h expected 0", $time,
			"read_en,write_en,inc_en,clr_en,alu_op,mem_wr",
			{read_en, write_en, inc_en, clr_en, alu_op, mem_wr});
	end

	a_refetch: assert property (@(posedge clock) disable iff (!arst_n)
		single_hit || other_hit |=> present == cu_seq_pkg::st_fetch1)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t present got %0d expected %0d", $time, present, cu_seq_pkg::st_fetch1);
	end

	a_jump_taken: assert property (@(posedge clock) disable iff (!arst_n)
		jump_taken |=> read_en == 4'd8 && write_en == 16'h0004)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t read_en/write_en got %h/%h expected 8/0004", $time, read_en, write_en);
	end

	a_jump_skip: assert property (@(posedge clock) disable iff (!arst_n)
		jump_skip |=> inc_en == 16'h0004 && write_en == 16'h0000)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t inc_en/write_en got %h/%h expected 0004/0000", $time, inc_en, write_en);
	end

	a_alu_first: assert property (@(posedge clock) disable iff (!arst_n)
		alu_hit |-> alu_op == alu_exp && write_en == 16'h0000)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t alu_op/write_en got %0d/%h expected %0d/0000", $time,
			alu_op, write_en, alu_exp);
	end

	// result captured on line 12
	a_alu_second: assert property (@(posedge clock) disable iff (!arst_n)
		alu_hit |=> alu_op == $past(alu_exp) && write_en == 16'h1000)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t alu_op/write_en got %0d/%h expected %0d/1000", $time,
			alu_op, write_en, alu_exp);
	end

	a_end_rise: assert property (@(posedge clock) disable iff (!arst_n)
		present == cu_seq_pkg::st_endop |=> end_process)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t end_process got %b expected 1", $time, end_process);
	end

	// halt never releases
	a_end_hold: assert property (@(posedge clock) disable iff (!arst_n)
		end_process |=> end_process)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t end_process got %b expected 1", $time, end_process);
	end

	a_end_late: assert property (@(posedge clock) disable iff (!arst_n)
		end_process |-> prev_state == cu_seq_pkg::st_endop)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t end_process got 1 expected 0 outside halt", $time);
	end

	a_end_bus: assert property (@(posedge clock) disable iff (!arst_n)
		end_process |-> read_en == 4'd14)
	else begin
		fail_count = fail_count + 1;
		$error("Error %0t read_en got %h expected e", $time, read_en);
	end

endmodule

bind control_unit control_unit_asserts u_asserts (
	.clock(clock),
	.arst_n(arst_n),
	.status(status),
	.instruction(instruction),
	.z(z),
	.present(present),
	.read_en(read_en),
	.write_en(write_en),
	.inc_en(inc_en),
	.clr_en(clr_en),
	.alu_op(alu_op),
	.mem_wr(mem_wr),
	.end_process(end_process)
);

`default_nettype wire

//--- control_unit.sv
`default_nettype none

module control_unit #(
	// enable line counts for the datapath
	localparam int WRITE_LINES = 16,
	localparam int INC_LINES = 16
) (
	input logic clock,
	input logic arst_n,
	input logic [cu_dp_pkg::DATA_W-1:0] z,
	input logic [1:0] status,
	input logic [15:0] instruction,
	output logic [cu_dp_pkg::ALU_OP_W-1:0] alu_op,
	output logic [WRITE_LINES-1:0] write_en,
	output logic [cu_dp_pkg::BUS_SRC_W-1:0] read_en,
	output logic [cu_dp_pkg::CLR_W-1:0] clr_en,
	output logic [INC_LINES-1:0] inc_en,
	output logic mem_wr,
	output logic end_process
);

	cu_seq_pkg::state_t present;

	// symbolic word between table and decoder
	ctrl_word_if cw ();

	// state register and branching
	ctrl_sequencer u_seq (
		.clock(clock),
		.arst_n(arst_n),
		.status(status),
		.instruction(instruction),
		.z(z),
		.present(present),
		.end_process(end_process)
	);

	// state to control word
	microcode_rom u_rom (
		.present(present),
		.word(cw.source)
	);

	// control word to output lines
	ctrl_line_decoder #(
		.WRITE_LINES(WRITE_LINES),
		.INC_LINES(INC_LINES)
	) u_dec (
		.word(cw.sink),
		.read_en(read_en),
		.write_en(write_en),
		.inc_en(inc_en),
		.clr_en(clr_en),
		.alu_op(alu_op),
		.mem_wr(mem_wr)
	);

endmodule

`default_nettype wire

//--- ctrl_line_decoder.sv
`default_nettype none

module ctrl_line_decoder #(
	parameter int WRITE_LINES = 16,
	parameter int INC_LINES = 16
) (
	ctrl_word_if.sink word,
	output logic [cu_dp_pkg::BUS_SRC_W-1:0] read_en,
	output logic [WRITE_LINES-1:0] write_en,
	output logic [INC_LINES-1:0] inc_en,
	output logic [cu_dp_pkg::CLR_W-1:0] clr_en,
	output logic [cu_dp_pkg::ALU_OP_W-1:0] alu_op,
	output logic mem_wr
);

	// encoded fields go straight out
	assign read_en = word.bus_src;
	assign clr_en = word.clr;
	assign alu_op = word.alu_op;
	assign mem_wr = word.mem_wr;

	// target index to one line, none clears all
	assign write_en = (word.dest == cu_dp_pkg::dst_none) ? '0 :
		(WRITE_LINES'(1) << word.dest);

	// same for increments
	assign inc_en = (word.inc == cu_dp_pkg::inc_none) ? '0 :
		(INC_LINES'(1) << word.inc);

endmodule

`default_nettype wire

//--- microcode_rom.sv
`default_nettype none

module microcode_rom (
	input cu_seq_pkg::state_t present,
	ctrl_word_if.source word
);

	// local view of one table row
	typedef struct packed {
		cu_dp_pkg::bus_src_t src;
		cu_dp_pkg::dest_t dst;
		cu_dp_pkg::inc_t inc;
		cu_dp_pkg::clr_t clr;
		cu_dp_pkg::alu_op_t alu;
		logic mem_wr;
	} uword_t;

	// nothing driven
	localparam uword_t UW_NONE = '{
		src: cu_dp_pkg::src_none,
		dst: cu_dp_pkg::dst_none,
		inc: cu_dp_pkg::inc_none,
		clr: cu_dp_pkg::clr_none,
		alu: cu_dp_pkg::alu_pass,
		mem_wr: 1'b0
	};

	uword_t uw;

	// bus transfer row, source onto bus and into target
	function automatic uword_t xfer(cu_dp_pkg::bus_src_t s, cu_dp_pkg::dest_t d);
		uword_t r;
		r = UW_NONE;
		r.src = s;
		r.dst = d;
		return r;
	endfunction

	always_comb begin
		uw = UW_NONE;
		case (present)
			// ir <= mem[pc]
			cu_seq_pkg::st_fetch1: uw = xfer(cu_dp_pkg::src_mem_pc, cu_dp_pkg::dst_ir);
			cu_seq_pkg::st_fetch2: uw.inc = cu_dp_pkg::inc_pc;
			// operand address from the word after the instruction
			cu_seq_pkg::st_loada1: begin
				uw = xfer(cu_dp_pkg::src_mem_pc, cu_dp_pkg::dst_ar);
				uw.inc = cu_dp_pkg::inc_pc;
			end
			cu_seq_pkg::st_loada2,
			cu_seq_pkg::st_loadb2: uw = xfer(cu_dp_pkg::src_mem_ar, cu_dp_pkg::dst_ac);
			// indirect, ac holds the address
			cu_seq_pkg::st_loadb1: uw = xfer(cu_dp_pkg::src_ac, cu_dp_pkg::dst_ar);
			cu_seq_pkg::st_store1: uw = xfer(cu_dp_pkg::src_ad, cu_dp_pkg::dst_ar);
			cu_seq_pkg::st_store2: begin
				uw = xfer(cu_dp_pkg::src_r2, cu_dp_pkg::dst_mem);
				uw.mem_wr = 1'b1;
			end
			// jump target into arp
			cu_seq_pkg::st_jumpz1,
			cu_seq_pkg::st_jumpn1: uw = xfer(cu_dp_pkg::src_mem_pc, cu_dp_pkg::dst_arp);
			cu_seq_pkg::st_jumpz2,
			cu_seq_pkg::st_jumpn2: uw = xfer(cu_dp_pkg::src_arp, cu_dp_pkg::dst_pc);
			// not taken, skip the target word
			cu_seq_pkg::st_jumpz3,
			cu_seq_pkg::st_jumpn3: uw.inc = cu_dp_pkg::inc_pc;
			cu_seq_pkg::st_mvr2r1: uw = xfer(cu_dp_pkg::src_r2, cu_dp_pkg::dst_r1);
			cu_seq_pkg::st_mvacarp: uw = xfer(cu_dp_pkg::src_ac, cu_dp_pkg::dst_arp);
			cu_seq_pkg::st_mvacacp: uw = xfer(cu_dp_pkg::src_ac, cu_dp_pkg::dst_acp);
			cu_seq_pkg::st_mvacbcp: uw = xfer(cu_dp_pkg::src_ac, cu_dp_pkg::dst_bcp);
			cu_seq_pkg::st_incam: uw.inc = cu_dp_pkg::inc_am;
			cu_seq_pkg::st_incan: uw.inc = cu_dp_pkg::inc_an;
			cu_seq_pkg::st_incbn: uw.inc = cu_dp_pkg::inc_bn;
			cu_seq_pkg::st_mvamr1: uw = xfer(cu_dp_pkg::src_am, cu_dp_pkg::dst_r1);
			cu_seq_pkg::st_mvanr1: uw = xfer(cu_dp_pkg::src_an, cu_dp_pkg::dst_r1);
			cu_seq_pkg::st_mvbnr1: uw = xfer(cu_dp_pkg::src_bn, cu_dp_pkg::dst_r1);
			cu_seq_pkg::st_mvarpac: uw = xfer(cu_dp_pkg::src_arp, cu_dp_pkg::dst_ac);
			cu_seq_pkg::st_mvacpac: uw = xfer(cu_dp_pkg::src_acp, cu_dp_pkg::dst_ac);
			cu_seq_pkg::st_mvbcpac: uw = xfer(cu_dp_pkg::src_bcp, cu_dp_pkg::dst_ac);
			cu_seq_pkg::st_mvaaac: uw = xfer(cu_dp_pkg::src_aa, cu_dp_pkg::dst_ac);
			cu_seq_pkg::st_mvabac: uw = xfer(cu_dp_pkg::src_ab, cu_dp_pkg::dst_ac);
			cu_seq_pkg::st_mvadac: uw = xfer(cu_dp_pkg::src_ad, cu_dp_pkg::dst_ac);
			cu_seq_pkg::st_mvacr1: uw = xfer(cu_dp_pkg::src_ac, cu_dp_pkg::dst_r1);
			cu_seq_pkg::st_mvacr2: uw = xfer(cu_dp_pkg::src_ac, cu_dp_pkg::dst_r2);
			// first cycle settles the alu, second captures it
			cu_seq_pkg::st_multi: uw.alu = cu_dp_pkg::alu_mul;
			cu_seq_pkg::st_multi1x: begin
				uw.alu = cu_dp_pkg::alu_mul;
				uw.dst = cu_dp_pkg::dst_alu;
			end
			cu_seq_pkg::st_add: uw.alu = cu_dp_pkg::alu_add;
			cu_seq_pkg::st_add1x: begin
				uw.alu = cu_dp_pkg::alu_add;
				uw.dst = cu_dp_pkg::dst_alu;
			end
			cu_seq_pkg::st_sub: uw.alu = cu_dp_pkg::alu_sub;
			cu_seq_pkg::st_sub1x: begin
				uw.alu = cu_dp_pkg::alu_sub;
				uw.dst = cu_dp_pkg::dst_alu;
			end
			cu_seq_pkg::st_rstan: uw.clr = cu_dp_pkg::clr_an;
			cu_seq_pkg::st_rstr2: uw.clr = cu_dp_pkg::clr_r2;
			// memory stays on the bus while halted
			cu_seq_pkg::st_endop: uw.src = cu_dp_pkg::src_mem_ar;
			// idle, gap states and nop
			default: uw = UW_NONE;
		endcase
	end

	assign word.bus_src = uw.src;
	assign word.dest = uw.dst;
	assign word.inc = uw.inc;
	assign word.clr = uw.clr;
	assign word.alu_op = uw.alu;
	assign word.mem_wr = uw.mem_wr;

endmodule

`default_nettype wire

//--- ctrl_sequencer.sv
`default_nettype none

module ctrl_sequencer (
	input logic clock,
	input logic arst_n,
	input logic [1:0] status,
	input logic [15:0] instruction,
	input logic [cu_dp_pkg::DATA_W-1:0] z,
	output cu_seq_pkg::state_t present,
	output logic end_process
);

	cu_seq_pkg::state_t next_state;
	logic [cu_seq_pkg::CLASS_MSB-cu_seq_pkg::CLASS_LSB:0] class_field;
	logic [cu_seq_pkg::OPCODE_W-1:0] op_field;
	logic is_exec;

	assign class_field = instruction[cu_seq_pkg::CLASS_MSB:cu_seq_pkg::CLASS_LSB];
	assign op_field = instruction[cu_seq_pkg::OPCODE_W-1:0];
	// classes 8 and 15 carry a real opcode
	assign is_exec = (class_field == cu_seq_pkg::CLASS_EXEC_A) ||
		(class_field == cu_seq_pkg::CLASS_EXEC_B);

	always_comb begin
		// last state of every sequence goes back to fetch
		next_state = cu_seq_pkg::st_fetch1;
		case (present)
			cu_seq_pkg::st_idle: begin
				// hold until start
				if (status != cu_seq_pkg::START_STATUS) begin
					next_state = cu_seq_pkg::st_idle;
				end
			end
			cu_seq_pkg::st_fetch1: next_state = cu_seq_pkg::st_fetch1x;
			cu_seq_pkg::st_fetch1x: next_state = cu_seq_pkg::st_fetch2;
			cu_seq_pkg::st_fetch2: next_state = cu_seq_pkg::st_fetch2x;
			cu_seq_pkg::st_fetch2x: begin
				if (!is_exec) begin
					// other classes idle through one nop
					next_state = cu_seq_pkg::st_nop;
				end else begin
					// opcode value is the entry state
					case (op_field)
						cu_seq_pkg::op_loada, cu_seq_pkg::op_loadb,
						cu_seq_pkg::op_store, cu_seq_pkg::op_jumpz,
						cu_seq_pkg::op_jumpn, cu_seq_pkg::op_mvr2r1,
						cu_seq_pkg::op_mvacarp, cu_seq_pkg::op_mvacacp,
						cu_seq_pkg::op_mvacbcp, cu_seq_pkg::op_incam,
						cu_seq_pkg::op_incan, cu_seq_pkg::op_incbn,
						cu_seq_pkg::op_mvamr1, cu_seq_pkg::op_mvanr1,
						cu_seq_pkg::op_mvbnr1, cu_seq_pkg::op_mvarpac,
						cu_seq_pkg::op_mvacpac, cu_seq_pkg::op_mvbcpac,
						cu_seq_pkg::op_mvaaac, cu_seq_pkg::op_mvabac,
						cu_seq_pkg::op_mvadac, cu_seq_pkg::op_mvacr1,
						cu_seq_pkg::op_mvacr2, cu_seq_pkg::op_multi,
						cu_seq_pkg::op_add, cu_seq_pkg::op_sub,
						cu_seq_pkg::op_rstan, cu_seq_pkg::op_rstr2,
						cu_seq_pkg::op_nop, cu_seq_pkg::op_end: begin
							next_state = cu_seq_pkg::state_t'(op_field);
						end
						// unknown opcode, refetch
						default: next_state = cu_seq_pkg::st_fetch1;
					endcase
				end
			end
			cu_seq_pkg::st_loada1: next_state = cu_seq_pkg::st_loada2;
			cu_seq_pkg::st_loadb1: next_state = cu_seq_pkg::st_loadb1x;
			cu_seq_pkg::st_loadb1x: next_state = cu_seq_pkg::st_loadb2;
			cu_seq_pkg::st_store1: next_state = cu_seq_pkg::st_store2;
			cu_seq_pkg::st_jumpz1: begin
				// taken when z is zero
				next_state = (z == '0) ? cu_seq_pkg::st_jumpz2 : cu_seq_pkg::st_jumpz3;
			end
			cu_seq_pkg::st_jumpz2: next_state = cu_seq_pkg::st_jumpz2x;
			cu_seq_pkg::st_jumpz3: next_state = cu_seq_pkg::st_jumpz3x;
			cu_seq_pkg::st_jumpn1: begin
				// taken when z is nonzero
				next_state = (z != '0) ? cu_seq_pkg::st_jumpn2 : cu_seq_pkg::st_jumpn3;
			end
			cu_seq_pkg::st_jumpn2: next_state = cu_seq_pkg::st_jumpn2x;
			cu_seq_pkg::st_jumpn3: next_state = cu_seq_pkg::st_jumpn3x;
			cu_seq_pkg::st_multi: next_state = cu_seq_pkg::st_multi1x;
			cu_seq_pkg::st_add: next_state = cu_seq_pkg::st_add1x;
			cu_seq_pkg::st_sub: next_state = cu_seq_pkg::st_sub1x;
			// parked until reset
			cu_seq_pkg::st_endop: next_state = cu_seq_pkg::st_endop;
			default: next_state = cu_seq_pkg::st_fetch1;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			present <= cu_seq_pkg::st_idle;
			end_process <= 1'b0;
		end else begin
			present <= next_state;
			// one cycle behind the end state
			end_process <= (present == cu_seq_pkg::st_endop);
		end
	end

endmodule

`default_nettype wire

//--- ctrl_word_if.sv
`default_nettype none

// one symbolic control word per cycle
interface ctrl_word_if;

	cu_dp_pkg::bus_src_t bus_src;
	cu_dp_pkg::dest_t dest;
	cu_dp_pkg::inc_t inc;
	cu_dp_pkg::clr_t clr;
	cu_dp_pkg::alu_op_t alu_op;
	// memory write strobe
	logic mem_wr;

	// microcode table side
	modport source (output bus_src, dest, inc, clr, alu_op, mem_wr);
	// line decoder side
	modport sink (input bus_src, dest, inc, clr, alu_op, mem_wr);

endinterface

`default_nettype wire

//--- cu_dp_pkg.sv
`default_nettype none

package cu_dp_pkg;

	// datapath word
	localparam int DATA_W = 16;

	// control field widths
	localparam int BUS_SRC_W = 4;
	localparam int DEST_W = 4;
	localparam int INC_W = 3;
	localparam int CLR_W = 3;
	localparam int ALU_OP_W = 3;

	// bus source, value is the read_en code
	typedef enum logic [BUS_SRC_W-1:0] {
		src_none = 4'd0,
		src_aa = 4'd1,
		src_r2 = 4'd2,
		src_ab = 4'd3,
		src_am = 4'd5,
		src_an = 4'd6,
		src_bn = 4'd7,
		src_arp = 4'd8,
		src_acp = 4'd9,
		src_bcp = 4'd10,
		src_ac = 4'd12,
		src_ad = 4'd13,
		// memory read, addressed by ar or by pc
		src_mem_ar = 4'd14,
		src_mem_pc = 4'd15
	} bus_src_t;

	// write target, value is the write_en line index
	// none sits on the spare top code
	typedef enum logic [DEST_W-1:0] {
		dst_ar = 4'd0,
		dst_r2 = 4'd1,
		dst_pc = 4'd2,
		dst_ir = 4'd3,
		dst_arp = 4'd7,
		dst_acp = 4'd8,
		dst_bcp = 4'd9,
		dst_r1 = 4'd10,
		dst_ac = 4'd11,
		dst_alu = 4'd12,
		dst_mem = 4'd13,
		dst_none = 4'd15
	} dest_t;

	// increment target, value is the inc_en line index
	typedef enum logic [INC_W-1:0] {
		inc_pc = 3'd2,
		inc_am = 3'd4,
		inc_an = 3'd5,
		inc_bn = 3'd6,
		inc_none = 3'd7
	} inc_t;

	// clear code, driven as is
	typedef enum logic [CLR_W-1:0] {
		clr_none = 3'b000,
		clr_an = 3'b001,
		clr_r2 = 3'b010
	} clr_t;

	typedef enum logic [ALU_OP_W-1:0] {
		alu_pass = 3'd0,
		alu_mul = 3'd1,
		alu_add = 3'd2,
		alu_sub = 3'd3
	} alu_op_t;

endpackage

`default_nettype wire

//--- cu_seq_pkg.sv
`default_nettype none

package cu_seq_pkg;

	// class field of the instruction word
	localparam int CLASS_MSB = 15;
	localparam int CLASS_LSB = 12;
	// opcode sits in the low bits
	localparam int OPCODE_W = 6;

	// only these classes reach the opcode dispatch
	localparam logic [CLASS_MSB-CLASS_LSB:0] CLASS_EXEC_A = 4'd8;
	localparam logic [CLASS_MSB-CLASS_LSB:0] CLASS_EXEC_B = 4'd15;

	// status value that leaves idle
	localparam logic [1:0] START_STATUS = 2'b01;

	// microcode states
	// first execute state of each instruction equals its opcode
	typedef enum logic [OPCODE_W-1:0] {
		st_idle = 6'd0,
		st_fetch1 = 6'd1,
		st_fetch2 = 6'd2,
		st_fetch1x = 6'd50,
		st_fetch2x = 6'd51,
		// loads and store
		st_loada1 = 6'd3, st_loada2 = 6'd4,
		st_loadb1 = 6'd5, st_loadb1x = 6'd54, st_loadb2 = 6'd6,
		st_store1 = 6'd7, st_store2 = 6'd8,
		// jump if zero, taken path 2, fall-through path 3
		st_jumpz1 = 6'd9, st_jumpz2 = 6'd10, st_jumpz3 = 6'd11,
		st_jumpz2x = 6'd60, st_jumpz3x = 6'd57,
		// jump if nonzero
		st_jumpn1 = 6'd13, st_jumpn2 = 6'd14, st_jumpn3 = 6'd15,
		st_jumpn2x = 6'd16, st_jumpn3x = 6'd17,
		// single cycle register moves
		st_mvr2r1 = 6'd20,
		st_mvacarp = 6'd23, st_mvacacp = 6'd24, st_mvacbcp = 6'd25,
		// pointer and counter increments
		st_incam = 6'd26, st_incan = 6'd27, st_incbn = 6'd28,
		st_mvamr1 = 6'd29, st_mvanr1 = 6'd30, st_mvbnr1 = 6'd31,
		st_mvarpac = 6'd32, st_mvacpac = 6'd33, st_mvbcpac = 6'd34,
		st_mvaaac = 6'd35, st_mvabac = 6'd36, st_mvadac = 6'd37,
		st_mvacr1 = 6'd38, st_mvacr2 = 6'd39,
		// alu ops, second state writes the result
		st_multi = 6'd41, st_multi1x = 6'd61,
		st_add = 6'd42, st_add1x = 6'd62,
		st_sub = 6'd43, st_sub1x = 6'd58,
		// register clears
		st_rstan = 6'd45, st_rstr2 = 6'd46,
		st_nop = 6'd47,
		st_endop = 6'd48
	} state_t;

	// opcodes accepted by the dispatch
	typedef enum logic [OPCODE_W-1:0] {
		op_loada = 6'd3, op_loadb = 6'd5, op_store = 6'd7,
		op_jumpz = 6'd9, op_jumpn = 6'd13,
		op_mvr2r1 = 6'd20,
		op_mvacarp = 6'd23, op_mvacacp = 6'd24, op_mvacbcp = 6'd25,
		op_incam = 6'd26, op_incan = 6'd27, op_incbn = 6'd28,
		op_mvamr1 = 6'd29, op_mvanr1 = 6'd30, op_mvbnr1 = 6'd31,
		op_mvarpac = 6'd32, op_mvacpac = 6'd33, op_mvbcpac = 6'd34,
		op_mvaaac = 6'd35, op_mvabac = 6'd36, op_mvadac = 6'd37,
		op_mvacr1 = 6'd38, op_mvacr2 = 6'd39,
		op_multi = 6'd41, op_add = 6'd42, op_sub = 6'd43,
		op_rstan = 6'd45, op_rstr2 = 6'd46,
		op_nop = 6'd47,
		op_end = 6'd48
	} opcode_t;

endpackage

`default_nettype wire
